// ==== rtl/gfx_consts.svh ====
`ifndef GFX_CONSTS_SVH
`define GFX_CONSTS_SVH

// framebuffer striping across the sram banks
`define GFX_NUM_BANKS 2
`define GFX_PIXEL_BITS 12
`define GFX_SRAM_DATA_BITS 16
`define GFX_SRAM_ADDR_BITS 6

// linear pixel address, y * visible width + x
`define GFX_FB_ADDR_BITS 7

// horizontal timing in pixels, visible area first
`define GFX_H_VISIBLE 16
`define GFX_H_FRONT_PORCH 2
`define GFX_H_SYNC_PULSE 3
`define GFX_H_BACK_PORCH 3
`define GFX_H_WHOLE_LINE \
  (`GFX_H_VISIBLE + `GFX_H_FRONT_PORCH + `GFX_H_SYNC_PULSE + `GFX_H_BACK_PORCH)

// vertical timing in lines
`define GFX_V_VISIBLE 8
`define GFX_V_FRONT_PORCH 1
`define GFX_V_SYNC_PULSE 2
`define GFX_V_BACK_PORCH 1
`define GFX_V_WHOLE_FRAME \
  (`GFX_V_VISIBLE + `GFX_V_FRONT_PORCH + `GFX_V_SYNC_PULSE + `GFX_V_BACK_PORCH)

// pixel clock crossing
`define GFX_FIFO_ADDR_BITS 4
`define GFX_FIFO_ALMOST_FULL_MARGIN 8

`endif

// ==== rtl/gfx_pkg.sv ====
`default_nettype none

`include "gfx_consts.svh"

package gfx_pkg;

  // coordinates inside the visible area
  typedef logic [$clog2(`GFX_H_VISIBLE)-1:0] gfx_x_t;
  typedef logic [$clog2(`GFX_V_VISIBLE)-1:0] gfx_y_t;

  // one nibble per channel
  typedef struct packed {
    logic [`GFX_PIXEL_BITS/3-1:0] red;
    logic [`GFX_PIXEL_BITS/3-1:0] grn;
    logic [`GFX_PIXEL_BITS/3-1:0] blu;
  } gfx_color_t;

  // stored pixel, color in the low bits
  typedef struct packed {
    logic [`GFX_SRAM_DATA_BITS-`GFX_PIXEL_BITS-1:0] pad;
    gfx_color_t                                     color;
  } fb_pixel_t;

  // sram word, moved raw by the memory side
  typedef union packed {
    logic [`GFX_SRAM_DATA_BITS-1:0] raw;
    fb_pixel_t                      pix;
  } fb_word_u;

  // one display sample, sync plus color
  typedef struct packed {
    logic       hsync;
    logic       vsync;
    gfx_color_t color;
  } vga_out_t;

endpackage

`default_nettype wire

// ==== rtl/mem_pkg.sv ====
`default_nettype none

`include "gfx_consts.svh"

package mem_pkg;

  // word address inside one bank
  typedef logic [`GFX_SRAM_ADDR_BITS-1:0] bank_addr_t;

  // single-beat access from a peer to a bank arbiter
  typedef struct packed {
    logic                           valid;
    logic                           we;
    bank_addr_t                     addr;
    logic [`GFX_SRAM_DATA_BITS-1:0] data;
  } bank_req_t;

endpackage

`default_nettype wire

// ==== rtl/fb_writer.sv ====
`default_nettype none

`include "gfx_consts.svh"

module fb_writer (
  input  logic                                    clk,
  input  logic                                    rst,
  input  gfx_pkg::gfx_x_t                         gfx_x,
  input  gfx_pkg::gfx_y_t                         gfx_y,
  input  gfx_pkg::gfx_color_t                     gfx_color,
  input  logic                                    gfx_valid,
  output logic                                    gfx_ready,
  output mem_pkg::bank_req_t [`GFX_NUM_BANKS-1:0] wr_req,
  input  logic [`GFX_NUM_BANKS-1:0]               wr_grant
);
  localparam int addr_bits = `GFX_FB_ADDR_BITS;

  logic [addr_bits-1:0] lin_addr;
  gfx_pkg::fb_word_u    new_word;
  logic                 accept;
  logic                 grant_hit;

  // the single pixel in flight
  logic                 pend_valid;
  logic                 pend_bank;
  mem_pkg::bank_addr_t  pend_addr;
  gfx_pkg::fb_word_u    pend_word;

  assign lin_addr = addr_bits'(gfx_y) * addr_bits'(`GFX_H_VISIBLE) + addr_bits'(gfx_x);

  always_comb begin
    new_word.pix.pad   = '0;
    new_word.pix.color = gfx_color;
  end

  // the grant frees the slot in the same cycle
  assign grant_hit = pend_valid & wr_grant[pend_bank];
  assign gfx_ready = ~pend_valid | grant_hit;
  assign accept    = gfx_valid & gfx_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      pend_valid <= 1'b0;
    end else if (accept) begin
      pend_valid <= 1'b1;
    end else if (grant_hit) begin
      pend_valid <= 1'b0;
    end
  end

  // even pixels to bank 0, odd to bank 1
  always_ff @(posedge clk) begin
    if (accept) begin
      pend_bank <= lin_addr[0];
      pend_addr <= lin_addr[addr_bits-1:1];
      pend_word <= new_word;
    end
  end

  always_comb begin
    for (int b = 0; b < `GFX_NUM_BANKS; b++) begin
      wr_req[b].valid = pend_valid && (int'(pend_bank) == b);
      wr_req[b].we    = 1'b1;
      wr_req[b].addr  = pend_addr;
      wr_req[b].data  = pend_word.raw;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/vga_scan_reader.sv ====
`default_nettype none

`include "gfx_consts.svh"

module vga_scan_reader (
  input  logic                                                clk,
  input  logic                                                rst,
  input  logic                                                enable,
  output mem_pkg::bank_req_t [`GFX_NUM_BANKS-1:0]             rd_req,
  input  logic [`GFX_NUM_BANKS-1:0][`GFX_SRAM_DATA_BITS-1:0] rd_data,
  input  logic [`GFX_NUM_BANKS-1:0]                           rd_valid,
  output gfx_pkg::vga_out_t                                   pix,
  output logic                                                pix_valid
);
  localparam int h_bits    = $clog2(`GFX_H_WHOLE_LINE);
  localparam int v_bits    = $clog2(`GFX_V_WHOLE_FRAME);
  localparam int addr_bits = `GFX_FB_ADDR_BITS;

  typedef logic [h_bits-1:0] h_cnt_t;
  typedef logic [v_bits-1:0] v_cnt_t;

  localparam h_cnt_t h_visible    = h_cnt_t'(`GFX_H_VISIBLE);
  localparam h_cnt_t h_sync_start = h_cnt_t'(`GFX_H_VISIBLE + `GFX_H_FRONT_PORCH);
  localparam h_cnt_t h_sync_end   =
    h_cnt_t'(`GFX_H_VISIBLE + `GFX_H_FRONT_PORCH + `GFX_H_SYNC_PULSE);
  localparam h_cnt_t h_last       = h_cnt_t'(`GFX_H_WHOLE_LINE - 1);

  localparam v_cnt_t v_visible    = v_cnt_t'(`GFX_V_VISIBLE);
  localparam v_cnt_t v_sync_start = v_cnt_t'(`GFX_V_VISIBLE + `GFX_V_FRONT_PORCH);
  localparam v_cnt_t v_sync_end   =
    v_cnt_t'(`GFX_V_VISIBLE + `GFX_V_FRONT_PORCH + `GFX_V_SYNC_PULSE);
  localparam v_cnt_t v_last       = v_cnt_t'(`GFX_V_WHOLE_FRAME - 1);

  // what a position needs once its read data is back
  typedef struct packed {
    logic valid;
    logic hsync;
    logic vsync;
    logic visible;
    logic bank;
  } scan_stage_t;

  h_cnt_t                                              h_cnt;
  v_cnt_t                                              v_cnt;
  logic [addr_bits-1:0]                                lin_addr;
  scan_stage_t                                         cur;
  scan_stage_t                                         s1;
  scan_stage_t                                         s2;
  logic [`GFX_NUM_BANKS-1:0][`GFX_SRAM_DATA_BITS-1:0] rd_hold;
  gfx_pkg::fb_word_u                                   ret_word;

  assign lin_addr = addr_bits'(v_cnt) * addr_bits'(`GFX_H_VISIBLE) + addr_bits'(h_cnt);

  always_comb begin
    cur.valid   = 1'b1;
    cur.visible = (h_cnt < h_visible) && (v_cnt < v_visible);
    cur.hsync   = (h_cnt >= h_sync_start) && (h_cnt < h_sync_end);
    // whole lines, not only the pulse positions
    cur.vsync   = (v_cnt >= v_sync_start) && (v_cnt < v_sync_end);
    cur.bank    = lin_addr[0];
  end

  // reads only for visible positions, to the pixel's stripe
  always_comb begin
    for (int b = 0; b < `GFX_NUM_BANKS; b++) begin
      rd_req[b].valid = enable && cur.visible && (int'(cur.bank) == b);
      rd_req[b].we    = 1'b0;
      rd_req[b].addr  = lin_addr[addr_bits-1:1];
      rd_req[b].data  = '0;
    end
  end

  // counters and both stages move together
  always_ff @(posedge clk) begin
    if (rst) begin
      h_cnt <= '0;
      v_cnt <= '0;
      s1    <= '0;
      s2    <= '0;
    end else if (enable) begin
      s1 <= cur;
      s2 <= s1;
      if (h_cnt == h_last) begin
        h_cnt <= '0;
        v_cnt <= (v_cnt == v_last) ? '0 : v_cnt + 1'b1;
      end else begin
        h_cnt <= h_cnt + 1'b1;
      end
    end
  end

  // keeps returned words while the pipeline is stalled
  always_ff @(posedge clk) begin
    for (int b = 0; b < `GFX_NUM_BANKS; b++) begin
      if (rd_valid[b]) begin
        rd_hold[b] <= rd_data[b];
      end
    end
  end

  // adjacent positions alternate banks, so one hold per bank suffices
  always_comb begin
    ret_word.raw = rd_valid[s2.bank] ? rd_data[s2.bank] : rd_hold[s2.bank];
    pix.hsync    = s2.hsync;
    pix.vsync    = s2.vsync;
    pix.color    = s2.visible ? ret_word.pix.color : '0;
    pix_valid    = enable & s2.valid;
  end

endmodule

`default_nettype wire

// ==== rtl/sram_bank_arbiter.sv ====
`default_nettype none

`include "gfx_consts.svh"

module sram_bank_arbiter (
  input  logic                           clk,
  input  logic                           rst,
  input  mem_pkg::bank_req_t             scan_req,
  input  mem_pkg::bank_req_t             wr_req,
  output logic                           wr_grant,
  output logic [`GFX_SRAM_DATA_BITS-1:0] rd_data,
  output logic                           rd_valid,
  output mem_pkg::bank_addr_t            sram_addr,
  output logic [`GFX_SRAM_DATA_BITS-1:0] sram_wdata,
  input  logic [`GFX_SRAM_DATA_BITS-1:0] sram_rdata,
  output logic                           sram_we_n,
  output logic                           sram_oe_n,
  output logic                           sram_ce_n
);
  mem_pkg::bank_req_t sel;

  // scanout runs on a fixed schedule, the writer always yields
  assign wr_grant = wr_req.valid & ~scan_req.valid;
  assign sel      = scan_req.valid ? scan_req : wr_req;

  // one cycle of strobes per granted access
  always_ff @(posedge clk) begin
    if (rst) begin
      sram_we_n <= 1'b1;
      sram_oe_n <= 1'b1;
      sram_ce_n <= 1'b1;
      rd_valid  <= 1'b0;
    end else begin
      sram_we_n <= ~(sel.valid & sel.we);
      sram_oe_n <= ~(sel.valid & ~sel.we);
      sram_ce_n <= ~sel.valid;
      rd_valid  <= ~sram_oe_n;
    end
  end

  always_ff @(posedge clk) begin
    sram_addr  <= sel.addr;
    sram_wdata <= sel.data;
    // sample at the end of the output-enable cycle
    if (!sram_oe_n) begin
      rd_data <= sram_rdata;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/cdc_fifo.sv ====
`default_nettype none

`include "gfx_consts.svh"

module cdc_fifo (
  input  logic              w_clk,
  input  logic              r_clk,
  input  logic              rst,
  input  logic              w_valid,
  input  gfx_pkg::vga_out_t w_data,
  output logic              w_almost_full,
  output gfx_pkg::vga_out_t r_data,
  output logic              r_empty
);
  localparam int addr_bits = `GFX_FIFO_ADDR_BITS;
  localparam int depth     = 1 << addr_bits;

  // one extra bit tells full from empty
  typedef logic [addr_bits:0] ptr_t;

  localparam ptr_t af_level = ptr_t'(depth - `GFX_FIFO_ALMOST_FULL_MARGIN);

  gfx_pkg::vga_out_t mem [depth];

  logic [1:0] w_rst_sync;
  logic [1:0] r_rst_sync;
  logic       w_rst;
  logic       r_rst;
  ptr_t       w_bin;
  ptr_t       w_gray;
  ptr_t       r_bin;
  ptr_t       r_gray;
  ptr_t       r_gray_w1;
  ptr_t       r_gray_w2;
  ptr_t       w_gray_r1;
  ptr_t       w_gray_r2;
  ptr_t       w_level;
  logic       w_full;
  logic       w_inc;

  function automatic ptr_t bin2gray(ptr_t b);
    return b ^ (b >> 1);
  endfunction

  function automatic ptr_t gray2bin(ptr_t g);
    ptr_t b;
    b[addr_bits] = g[addr_bits];
    for (int i = addr_bits - 1; i >= 0; i--) begin
      b[i] = b[i+1] ^ g[i];
    end
    return b;
  endfunction

  // reset brought into each clock domain
  always_ff @(posedge w_clk) begin
    w_rst_sync <= {w_rst_sync[0], rst};
  end

  always_ff @(posedge r_clk) begin
    r_rst_sync <= {r_rst_sync[0], rst};
  end

  assign w_rst = w_rst_sync[1];
  assign r_rst = r_rst_sync[1];

  // occupancy as seen by the writer, pessimistic by the sync delay
  assign w_level       = w_bin - gray2bin(r_gray_w2);
  assign w_full        = w_level[addr_bits];
  assign w_almost_full = (w_level >= af_level);
  assign w_inc         = w_valid & ~w_full;

  always_ff @(posedge w_clk) begin
    if (w_rst) begin
      w_bin     <= '0;
      w_gray    <= '0;
      r_gray_w1 <= '0;
      r_gray_w2 <= '0;
    end else begin
      r_gray_w1 <= r_gray;
      r_gray_w2 <= r_gray_w1;
      if (w_inc) begin
        w_bin  <= w_bin + 1'b1;
        w_gray <= bin2gray(w_bin + 1'b1);
      end
    end
  end

  always_ff @(posedge w_clk) begin
    if (w_inc) begin
      mem[w_bin[addr_bits-1:0]] <= w_data;
    end
  end

  assign r_empty = (r_gray == w_gray_r2);

  // pops every cycle it has data, holds the last word otherwise
  always_ff @(posedge r_clk) begin
    if (r_rst) begin
      r_bin     <= '0;
      r_gray    <= '0;
      w_gray_r1 <= '0;
      w_gray_r2 <= '0;
      r_data    <= '0;
    end else begin
      w_gray_r1 <= w_gray;
      w_gray_r2 <= w_gray_r1;
      if (!r_empty) begin
        r_bin  <= r_bin + 1'b1;
        r_gray <= bin2gray(r_bin + 1'b1);
        r_data <= mem[r_bin[addr_bits-1:0]];
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/gfx_vga_stripe.sv ====
`default_nettype none

`include "gfx_consts.svh"

module gfx_vga_stripe (
  input  logic                                                clk,
  input  logic                                                pixel_clk,
  input  logic                                                rst,

  // drawing client
  input  gfx_pkg::gfx_x_t                                     gfx_x,
  input  gfx_pkg::gfx_y_t                                     gfx_y,
  input  gfx_pkg::gfx_color_t                                 gfx_color,
  input  logic                                                gfx_valid,
  output logic                                                gfx_ready,

  // display, pixel_clk domain
  input  logic                                                vga_enable,
  output logic [`GFX_PIXEL_BITS/3-1:0]                        vga_red,
  output logic [`GFX_PIXEL_BITS/3-1:0]                        vga_grn,
  output logic [`GFX_PIXEL_BITS/3-1:0]                        vga_blu,
  output logic                                                vga_hsync,
  output logic                                                vga_vsync,

  // sram pins per bank
  output mem_pkg::bank_addr_t [`GFX_NUM_BANKS-1:0]            sram_addr,
  output logic [`GFX_NUM_BANKS-1:0][`GFX_SRAM_DATA_BITS-1:0] sram_wdata,
  input  logic [`GFX_NUM_BANKS-1:0][`GFX_SRAM_DATA_BITS-1:0] sram_rdata,
  output logic [`GFX_NUM_BANKS-1:0]                           sram_we_n,
  output logic [`GFX_NUM_BANKS-1:0]                           sram_oe_n,
  output logic [`GFX_NUM_BANKS-1:0]                           sram_ce_n
);
  mem_pkg::bank_req_t [`GFX_NUM_BANKS-1:0]             wr_req;
  logic [`GFX_NUM_BANKS-1:0]                           wr_grant;
  mem_pkg::bank_req_t [`GFX_NUM_BANKS-1:0]             scan_req;
  logic [`GFX_NUM_BANKS-1:0][`GFX_SRAM_DATA_BITS-1:0] rd_data;
  logic [`GFX_NUM_BANKS-1:0]                           rd_valid;
  logic                                                scan_enable;
  gfx_pkg::vga_out_t                                   scan_pix;
  logic                                                scan_pix_valid;
  logic                                                fifo_almost_full;
  gfx_pkg::vga_out_t                                   vga_pix;

  // scanout pauses before the crossing fills up
  assign scan_enable = vga_enable & ~fifo_almost_full;

  assign vga_hsync = vga_pix.hsync;
  assign vga_vsync = vga_pix.vsync;
  assign vga_red   = vga_pix.color.red;
  assign vga_grn   = vga_pix.color.grn;
  assign vga_blu   = vga_pix.color.blu;

  fb_writer i_fb_writer (
    .clk      (clk),
    .rst      (rst),
    .gfx_x    (gfx_x),
    .gfx_y    (gfx_y),
    .gfx_color(gfx_color),
    .gfx_valid(gfx_valid),
    .gfx_ready(gfx_ready),
    .wr_req   (wr_req),
    .wr_grant (wr_grant)
  );

  vga_scan_reader i_vga_scan_reader (
    .clk      (clk),
    .rst      (rst),
    .enable   (scan_enable),
    .rd_req   (scan_req),
    .rd_data  (rd_data),
    .rd_valid (rd_valid),
    .pix      (scan_pix),
    .pix_valid(scan_pix_valid)
  );

  for (genvar i = 0; i < `GFX_NUM_BANKS; i++) begin : gen_bank
    sram_bank_arbiter i_sram_bank_arbiter (
      .clk       (clk),
      .rst       (rst),
      .scan_req  (scan_req[i]),
      .wr_req    (wr_req[i]),
      .wr_grant  (wr_grant[i]),
      .rd_data   (rd_data[i]),
      .rd_valid  (rd_valid[i]),
      .sram_addr (sram_addr[i]),
      .sram_wdata(sram_wdata[i]),
      .sram_rdata(sram_rdata[i]),
      .sram_we_n (sram_we_n[i]),
      .sram_oe_n (sram_oe_n[i]),
      .sram_ce_n (sram_ce_n[i])
    );
  end

  cdc_fifo i_cdc_fifo (
    .w_clk        (clk),
    .r_clk        (pixel_clk),
    .rst          (rst),
    .w_valid      (scan_pix_valid),
    .w_data       (scan_pix),
    .w_almost_full(fifo_almost_full),
    .r_data       (vga_pix),
    .r_empty      ()
  );

endmodule

`default_nettype wire

// ==== tb/gfx_vga_stripe_assert.sv ====
`default_nettype none

`include "gfx_consts.svh"

module gfx_vga_stripe_assert (
  input logic                      clk,
  input logic                      rst,
  input logic [`GFX_NUM_BANKS-1:0] sram_we_n,
  input logic [`GFX_NUM_BANKS-1:0] sram_oe_n,
  input logic [`GFX_NUM_BANKS-1:0] sram_ce_n
);

  // a bank cycle is a read or a write, never both
  we_oe_exclusive: assert property (
    @(posedge clk) disable iff (rst) (sram_we_n | sram_oe_n) == '1
  ) else $error("sram we_n and oe_n low together");

  // chip enable covers every strobe
  ce_with_strobe: assert property (
    @(posedge clk) disable iff (rst) (~sram_ce_n | (sram_we_n & sram_oe_n)) == '1
  ) else $error("sram strobe without ce_n");

  idle_in_reset: assert property (
    @(posedge clk) rst |=> (&sram_we_n && &sram_oe_n && &sram_ce_n)
  ) else $error("sram active during reset");

endmodule

bind gfx_vga_stripe gfx_vga_stripe_assert i_gfx_vga_stripe_assert (
  .clk      (clk),
  .rst      (rst),
  .sram_we_n(sram_we_n),
  .sram_oe_n(sram_oe_n),
  .sram_ce_n(sram_ce_n)
);

`default_nettype wire

// ==== tb/tb_gfx_vga_stripe.sv ====
`default_nettype none

`include "gfx_consts.svh"

module tb_gfx_vga_stripe;
  localparam int clk_period    = 40;
  localparam int pix_period    = 100;
  localparam int num_banks     = `GFX_NUM_BANKS;
  localparam int bank_words    = 1 << `GFX_SRAM_ADDR_BITS;
  localparam int fb_pixels     = `GFX_H_VISIBLE * `GFX_V_VISIBLE;
  localparam int frame_len     = `GFX_H_WHOLE_LINE * `GFX_V_WHOLE_FRAME;
  localparam int stim_len      = 24;
  localparam int first_len     = 14;
  // two frames per capture, one wait frame, the pause and some margin
  localparam int frames_in_run = 10;
  localparam int wd_limit      =
    stim_len * 20 * clk_period + frames_in_run * frame_len * pix_period;
  localparam logic [7:0] random_holdoff = 8'hff;

  typedef struct packed {
    gfx_pkg::gfx_x_t     x;
    gfx_pkg::gfx_y_t     y;
    gfx_pkg::gfx_color_t color;
    logic [7:0]          holdoff;
  } stim_t;

  // first 14 entries before scanout starts, the rest while it runs
  stim_t stim_table [stim_len] = '{
    '{4'd0, 3'd0, 12'hf00, 8'd0}, '{4'd1, 3'd0, 12'h0f0, 8'd0},
    '{4'd2, 3'd0, 12'h00f, 8'd0}, '{4'd15, 3'd0, 12'hfff, 8'd1},
    '{4'd0, 3'd1, 12'h123, 8'hff}, '{4'd7, 3'd3, 12'h456, 8'd0},
    '{4'd8, 3'd3, 12'h789, 8'hff}, '{4'd15, 3'd7, 12'habc, 8'd2},
    '{4'd0, 3'd7, 12'hdef, 8'd0}, '{4'd3, 3'd5, 12'h246, 8'hff},
    '{4'd4, 3'd5, 12'h8ac, 8'd0}, '{4'd10, 3'd2, 12'h135, 8'hff},
    '{4'd11, 3'd2, 12'h975, 8'd0}, '{4'd5, 3'd6, 12'hfed, 8'hff},
    '{4'd1, 3'd0, 12'ha5a, 8'd0}, '{4'd2, 3'd0, 12'h5a5, 8'd0},
    '{4'd3, 3'd0, 12'hc3c, 8'hff}, '{4'd7, 3'd3, 12'h111, 8'd0},
    '{4'd8, 3'd3, 12'h222, 8'd0}, '{4'd9, 3'd3, 12'h333, 8'hff},
    '{4'd15, 3'd7, 12'h0f0, 8'd0}, '{4'd6, 3'd4, 12'h777, 8'hff},
    '{4'd12, 3'd1, 12'he1e, 8'd0}, '{4'd13, 3'd1, 12'h1e1, 8'd0}
  };

  logic                                                clk;
  logic                                                pixel_clk;
  logic                                                rst;
  gfx_pkg::gfx_x_t                                     gfx_x;
  gfx_pkg::gfx_y_t                                     gfx_y;
  gfx_pkg::gfx_color_t                                 gfx_color;
  logic                                                gfx_valid;
  logic                                                gfx_ready;
  logic                                                vga_enable;
  logic [`GFX_PIXEL_BITS/3-1:0]                        vga_red;
  logic [`GFX_PIXEL_BITS/3-1:0]                        vga_grn;
  logic [`GFX_PIXEL_BITS/3-1:0]                        vga_blu;
  logic                                                vga_hsync;
  logic                                                vga_vsync;
  mem_pkg::bank_addr_t [`GFX_NUM_BANKS-1:0]            sram_addr;
  logic [`GFX_NUM_BANKS-1:0][`GFX_SRAM_DATA_BITS-1:0] sram_wdata;
  logic [`GFX_NUM_BANKS-1:0][`GFX_SRAM_DATA_BITS-1:0] sram_rdata;
  logic [`GFX_NUM_BANKS-1:0]                           sram_we_n;
  logic [`GFX_NUM_BANKS-1:0]                           sram_oe_n;
  logic [`GFX_NUM_BANKS-1:0]                           sram_ce_n;

  logic [`GFX_SRAM_DATA_BITS-1:0] bank_mem [num_banks][bank_words];
  gfx_pkg::gfx_color_t            ref_fb [fb_pixels];
  gfx_pkg::vga_out_t              cur_out;
  gfx_pkg::vga_out_t              sample_q [$];
  logic                           pop_next = 1'b0;
  int                             errors = 0;
  int                             checks = 0;
  int                             seed = 32'h550d_73d4;

  gfx_vga_stripe i_gfx_vga_stripe (.*);

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    pixel_clk = 1'b0;
    forever #(pix_period / 2) pixel_clk = ~pixel_clk;
  end

  // behavioral async sram, one per stripe
  initial begin
    for (int b = 0; b < num_banks; b++) begin
      for (int a = 0; a < bank_words; a++) begin
        bank_mem[b][a] <= '0;
      end
    end
  end

  always @(posedge clk) begin
    for (int b = 0; b < num_banks; b++) begin
      if (!sram_we_n[b] && !sram_ce_n[b]) begin
        bank_mem[b][sram_addr[b]] <= sram_wdata[b];
      end
    end
  end

  always_comb begin
    for (int b = 0; b < num_banks; b++) begin
      sram_rdata[b] = (!sram_oe_n[b] && !sram_ce_n[b]) ? bank_mem[b][sram_addr[b]] : '0;
    end
  end

  always_comb begin
    cur_out.hsync     = vga_hsync;
    cur_out.vsync     = vga_vsync;
    cur_out.color.red = vga_red;
    cur_out.color.grn = vga_grn;
    cur_out.color.blu = vga_blu;
  end

  // one sample per FIFO pop, taken mid pixel_clk cycle
  always @(negedge pixel_clk) begin
    if (pop_next) begin
      sample_q.push_back(cur_out);
    end
    pop_next = !i_gfx_vga_stripe.i_cdc_fifo.r_empty;
  end

  task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[ERROR] %0t %s: got 0x%0h, expected 0x%0h", $time, what, actual, expected);
    end
  endtask

  task automatic send_pixel(input stim_t s);
    gfx_x     = s.x;
    gfx_y     = s.y;
    gfx_color = s.color;
    gfx_valid = 1'b1;
    while (!gfx_ready) begin
      @(posedge clk);
      #2;
    end
    @(posedge clk);
    #2;
  endtask

  task automatic apply_table(input int first, input int last);
    int holdoff;
    @(posedge clk);
    #2;
    for (int i = first; i < last; i++) begin
      holdoff = int'(stim_table[i].holdoff);
      if (stim_table[i].holdoff == random_holdoff) begin
        holdoff = int'($unsigned($random(seed)) % 4);
      end
      repeat (holdoff) begin
        gfx_valid = 1'b0;
        @(posedge clk);
        #2;
      end
      send_pixel(stim_table[i]);
      ref_fb[int'(stim_table[i].y) * `GFX_H_VISIBLE + int'(stim_table[i].x)] =
        stim_table[i].color;
    end
    gfx_valid = 1'b0;
  endtask

  // last pixel granted, then its strobe cycle and the store
  task automatic wait_writes_done();
    while (!gfx_ready) begin
      @(posedge clk);
      #2;
    end
    repeat (3) @(posedge clk);
    #2;
  endtask

  task automatic check_banks(input string tag);
    for (int p = 0; p < fb_pixels; p++) begin
      compare(32'(bank_mem[p % num_banks][p / num_banks]), 32'({4'h0, ref_fb[p]}),
              $sformatf("%s pixel %0d in bank %0d", tag, p, p % num_banks));
    end
  endtask

  task automatic next_sample(output gfx_pkg::vga_out_t s);
    while (sample_q.size() == 0) begin
      @(negedge pixel_clk);
    end
    s = sample_q.pop_front();
  endtask

  task automatic capture_frame(input string tag);
    gfx_pkg::vga_out_t   s;
    gfx_pkg::vga_out_t   prev;
    gfx_pkg::gfx_color_t exp_color;
    logic                exp_hs;
    logic                exp_vs;
    int                  hs_count;
    int                  vs_lines;
    sample_q.delete();
    next_sample(prev);
    next_sample(s);
    while (!(prev.vsync && !s.vsync)) begin
      prev = s;
      next_sample(s);
    end
    // s opens the back porch, skip the rest of it
    repeat (`GFX_V_BACK_PORCH * `GFX_H_WHOLE_LINE - 1) next_sample(s);
    vs_lines = 0;
    for (int line = 0; line < `GFX_V_WHOLE_FRAME; line++) begin
      hs_count = 0;
      for (int pos = 0; pos < `GFX_H_WHOLE_LINE; pos++) begin
        next_sample(s);
        exp_hs = (pos >= `GFX_H_VISIBLE + `GFX_H_FRONT_PORCH) &&
                 (pos < `GFX_H_VISIBLE + `GFX_H_FRONT_PORCH + `GFX_H_SYNC_PULSE);
        exp_vs = (line >= `GFX_V_VISIBLE + `GFX_V_FRONT_PORCH) &&
                 (line < `GFX_V_VISIBLE + `GFX_V_FRONT_PORCH + `GFX_V_SYNC_PULSE);
        exp_color = (pos < `GFX_H_VISIBLE && line < `GFX_V_VISIBLE) ?
                    ref_fb[line * `GFX_H_VISIBLE + pos] : '0;
        compare(32'(s.hsync), 32'(exp_hs), $sformatf("%s hsync at %0d,%0d", tag, pos, line));
        compare(32'(s.vsync), 32'(exp_vs), $sformatf("%s vsync at %0d,%0d", tag, pos, line));
        compare(32'(s.color), 32'(exp_color), $sformatf("%s color at %0d,%0d", tag, pos, line));
        hs_count += int'(s.hsync);
        if (pos == 0 && s.vsync) begin
          vs_lines++;
        end
      end
      compare(32'(hs_count), 32'(`GFX_H_SYNC_PULSE), $sformatf("%s hsync length", tag));
    end
    compare(32'(vs_lines), 32'(`GFX_V_SYNC_PULSE), $sformatf("%s vsync lines", tag));
  endtask

  // outputs must hold still once the FIFO has drained
  task automatic check_pause();
    gfx_pkg::vga_out_t held;
    @(posedge clk);
    #2;
    vga_enable = 1'b0;
    repeat (40) @(negedge pixel_clk);
    held = cur_out;
    repeat (20) begin
      @(negedge pixel_clk);
      compare(32'(cur_out), 32'(held), "outputs during pause");
    end
    @(posedge clk);
    #2;
    vga_enable = 1'b1;
  endtask

  initial begin
    #(wd_limit);
    $display("timeout: run passed %0d time units without finishing", wd_limit);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    rst        = 1'b1;
    gfx_x      = '0;
    gfx_y      = '0;
    gfx_color  = '0;
    gfx_valid  = 1'b0;
    vga_enable = 1'b0;
    for (int p = 0; p < fb_pixels; p++) begin
      ref_fb[p] = '0;
    end
    repeat (5) @(posedge clk);
    #2;
    rst = 1'b0;

    compare(32'(gfx_ready), 32'd1, "gfx_ready after reset");
    compare(32'({sram_we_n, sram_oe_n, sram_ce_n}), 32'h3f, "sram enables after reset");
    repeat (10) @(posedge clk);
    #2;
    compare(32'(cur_out), 32'd0, "display outputs before data");

    apply_table(0, first_len);
    wait_writes_done();
    check_banks("first writes");

    vga_enable = 1'b1;
    capture_frame("first frame");

    // overwrites land while scanout holds the banks
    apply_table(first_len, stim_len);
    wait_writes_done();
    check_banks("overwrites");
    repeat (frame_len) @(posedge pixel_clk);
    capture_frame("overwritten frame");

    check_pause();
    capture_frame("frame after pause");

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+rtl
rtl/gfx_pkg.sv
rtl/mem_pkg.sv
rtl/fb_writer.sv
rtl/vga_scan_reader.sv
rtl/sram_bank_arbiter.sv
rtl/cdc_fifo.sv
rtl/gfx_vga_stripe.sv
tb/gfx_vga_stripe_assert.sv
tb/tb_gfx_vga_stripe.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_gfx_vga_stripe
RTL_TOP   ?= gfx_vga_stripe
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Finished with no errors
FAIL_MSG  ?= Finished with errors

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not complete"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
